/* src/fpu_bridge_pkg.sv */
// Bridge package with shared widths, ESC opcodes, CPU/core structs and sequencer states
package fpu_bridge_pkg;

    // =========================================================
    // Widths with a meaning
    // =========================================================
    typedef logic [79:0] word80_t;   // Extended-precision data
    typedef logic [15:0] word16_t;   // Control or status word
    typedef logic [7:0]  opcode_t;
    typedef logic [7:0]  modrm_t;

    // ESC opcode range
    localparam opcode_t ESC_D8 = 8'hD8;
    localparam opcode_t ESC_D9 = 8'hD9;
    localparam opcode_t ESC_DA = 8'hDA;
    localparam opcode_t ESC_DB = 8'hDB;
    localparam opcode_t ESC_DC = 8'hDC;
    localparam opcode_t ESC_DD = 8'hDD;
    localparam opcode_t ESC_DE = 8'hDE;
    localparam opcode_t ESC_DF = 8'hDF;

    localparam logic [1:0] MOD_REGISTER   = 2'd3;    // Register form of ModR/M
    localparam modrm_t     FSTSW_AX_MODRM = 8'hE0;
    localparam int         STATUS_MASK_BIT = 7;      // Set means exception suppressed
    localparam word16_t    CTRL_WORD_DEFAULT = 16'h037F;

    // =========================================================
    // Bundles
    // =========================================================
    typedef struct packed {
        opcode_t opcode;
        modrm_t  modrm;
    } esc_instr_t;

    typedef struct packed {
        opcode_t operation;
        modrm_t  operand_select;
        word80_t operand_data;
    } core_req_t;

    typedef struct packed {
        logic    complete;   // One-cycle pulse
        word80_t result;
        word16_t status;
        logic    error;
    } core_rsp_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_DECODE,
        SEQ_DATA_WAIT,
        SEQ_EXECUTE,
        SEQ_RESULT,
        SEQ_COMPLETE
    } seq_state_t;

endpackage

/* src/esc_decoder.sv */
// ESC instruction classifier: memory operand needed and result returned to the CPU
`timescale 1ns/1ps

module esc_decoder import fpu_bridge_pkg::*; (
    input  esc_instr_t instr,
    output logic       needs_operand,
    output logic       produces_result
);

    logic       reg_form;
    logic [2:0] reg_field;

    assign reg_form  = (instr.modrm[7:6] == MOD_REGISTER);
    assign reg_field = instr.modrm[5:3];

    always_comb begin
        needs_operand   = 1'b0;
        produces_result = 1'b0;

        case (instr.opcode)
            // Arithmetic with real or integer memory source
            ESC_D8, ESC_DA, ESC_DC, ESC_DE: begin
                needs_operand = !reg_form;
            end

            ESC_D9: begin
                if (!reg_form) begin
                    // FLD m32 and FLDCW load, FST m32 and FSTCW store
                    needs_operand   = (reg_field == 3'd0) || (reg_field == 3'd5);
                    produces_result = (reg_field == 3'd2) || (reg_field == 3'd7);
                end
            end

            ESC_DB: begin
                if (!reg_form) begin
                    needs_operand   = (reg_field != 3'd7);
                    produces_result = (reg_field == 3'd7);   // FSTP m80
                end
            end

            ESC_DD: begin
                if (!reg_form) begin
                    needs_operand = (reg_field == 3'd0);     // FLD m64
                    // FST m64 and FSTSW m16
                    produces_result = (reg_field == 3'd2) || (reg_field == 3'd7);
                end
            end

            ESC_DF: begin
                if (reg_form) begin
                    // Only FSTSW AX hands data back from a register form
                    produces_result = (instr.modrm == FSTSW_AX_MODRM);
                end else begin
                    needs_operand = 1'b1;
                end
            end

            default: begin
                // Not an ESC opcode
                needs_operand   = 1'b0;
                produces_result = 1'b0;
            end
        endcase
    end

endmodule

/* src/bridge_sequencer.sv */
// Bridge sequencer: accepts an ESC instruction, collects the operand, runs the core, returns the result
`timescale 1ns/1ps

module bridge_sequencer import fpu_bridge_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       instr_valid,
    input  esc_instr_t instr,
    output logic       instr_ack,

    input  logic       needs_operand,     // Live decode of instr
    input  logic       produces_result,

    input  logic       data_write,
    input  word80_t    data_in,
    input  logic       data_read,
    output word80_t    data_out,
    output logic       data_ready,

    output logic       fpu_start,
    output core_req_t  fpu_req,
    input  core_rsp_t  fpu_rsp,

    output logic       busy
);

    seq_state_t state;
    seq_state_t next_state;

    esc_instr_t instr_q;
    logic       needs_operand_q;
    logic       produces_result_q;
    logic       decode_phase;      // High in the second decode cycle
    word80_t    result_q;
    core_req_t  req_q;
    logic       accept;
    logic       enter_execute;

    assign accept        = (state == SEQ_IDLE) && instr_valid;
    assign enter_execute = (next_state == SEQ_EXECUTE) && (state != SEQ_EXECUTE);

    // ========================================================
    // Next state
    // ========================================================
    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE:      if (instr_valid) next_state = SEQ_DECODE;
            SEQ_DECODE: begin
                if (decode_phase) begin
                    next_state = needs_operand_q ? SEQ_DATA_WAIT : SEQ_EXECUTE;
                end
            end
            SEQ_DATA_WAIT: if (data_write) next_state = SEQ_EXECUTE;
            SEQ_EXECUTE: begin
                if (fpu_rsp.complete) begin
                    next_state = produces_result_q ? SEQ_RESULT : SEQ_COMPLETE;
                end
            end
            SEQ_RESULT:    if (data_read) next_state = SEQ_COMPLETE;
            SEQ_COMPLETE:  next_state = SEQ_IDLE;
            default:       next_state = SEQ_IDLE;
        endcase
    end

    // ========================================================
    // Control registers
    // ========================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state             <= SEQ_IDLE;
            instr_ack         <= 1'b0;
            fpu_start         <= 1'b0;
            decode_phase      <= 1'b0;
            needs_operand_q   <= 1'b0;
            produces_result_q <= 1'b0;
        end else begin
            state        <= next_state;
            instr_ack    <= accept;          // One cycle, idle only
            fpu_start    <= enter_execute;   // First cycle of execute
            decode_phase <= (state == SEQ_DECODE) && !decode_phase;
            if (accept) begin
                needs_operand_q   <= needs_operand;
                produces_result_q <= produces_result;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
        if (enter_execute) begin
            req_q.operation      <= instr_q.opcode;
            req_q.operand_select <= instr_q.modrm;
            // Operand arrives on the same edge that leaves data_wait
            req_q.operand_data   <= (state == SEQ_DATA_WAIT) ? data_in : '0;
        end
        if ((state == SEQ_EXECUTE) && fpu_rsp.complete) begin
            result_q <= fpu_rsp.result;
        end
    end

    assign fpu_req    = req_q;
    assign data_out   = result_q;
    assign data_ready = (state == SEQ_RESULT);   // Held until data_read
    assign busy       = (state != SEQ_IDLE);

endmodule

/* src/control_status.sv */
// Control word register with update pulse, plus status mirror and exception/interrupt lines
`timescale 1ns/1ps

module control_status import fpu_bridge_pkg::*; #(
    parameter word16_t CTRL_RESET = CTRL_WORD_DEFAULT
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      busy,
    input  logic      ctrl_write,
    input  word16_t   control_word,
    output word16_t   fpu_control_reg,
    output logic      fpu_control_update,
    input  core_rsp_t fpu_rsp,
    output word16_t   status_word,
    output logic      exception,
    output logic      irq
);

    logic write_accept;

    assign write_accept = ctrl_write && !busy;   // Writes while busy are dropped

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fpu_control_reg    <= CTRL_RESET;
            fpu_control_update <= 1'b0;
        end else begin
            fpu_control_update <= write_accept;
            if (write_accept) begin
                fpu_control_reg <= control_word;
            end
        end
    end

    // Status path is purely combinational
    assign status_word = fpu_rsp.status;
    assign exception   = fpu_rsp.error && !fpu_rsp.status[STATUS_MASK_BIT];
    assign irq         = exception;

endmodule

/* src/fpu_cpu_bridge.sv */
// CPU to floating-point core bridge top level: decoder, sequencer and control/status block
`timescale 1ns/1ps

module fpu_cpu_bridge import fpu_bridge_pkg::*; #(
    parameter word16_t CTRL_RESET = CTRL_WORD_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,

    // CPU side
    input  logic       instr_valid,
    input  esc_instr_t instr,
    output logic       instr_ack,
    input  logic       data_write,
    input  word80_t    data_in,
    input  logic       data_read,
    output word80_t    data_out,
    output logic       data_ready,
    output logic       busy,
    output logic       ready,
    input  logic       ctrl_write,
    input  word16_t    control_word,
    output word16_t    status_word,
    output logic       exception,
    output logic       irq,

    // Core side
    output logic       fpu_start,
    output core_req_t  fpu_req,
    input  core_rsp_t  fpu_rsp,
    output word16_t    fpu_control_reg,
    output logic       fpu_control_update
);

    logic needs_operand;
    logic produces_result;

    esc_decoder u_decoder (
        .instr           (instr),
        .needs_operand   (needs_operand),
        .produces_result (produces_result)
    );

    bridge_sequencer u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .instr_ack       (instr_ack),
        .needs_operand   (needs_operand),
        .produces_result (produces_result),
        .data_write      (data_write),
        .data_in         (data_in),
        .data_read       (data_read),
        .data_out        (data_out),
        .data_ready      (data_ready),
        .fpu_start       (fpu_start),
        .fpu_req         (fpu_req),
        .fpu_rsp         (fpu_rsp),
        .busy            (busy)
    );

    control_status #(
        .CTRL_RESET (CTRL_RESET)
    ) u_ctrl_status (
        .clk                (clk),
        .reset              (reset),
        .busy               (busy),
        .ctrl_write         (ctrl_write),
        .control_word       (control_word),
        .fpu_control_reg    (fpu_control_reg),
        .fpu_control_update (fpu_control_update),
        .fpu_rsp            (fpu_rsp),
        .status_word        (status_word),
        .exception          (exception),
        .irq                (irq)
    );

    assign ready = !busy;

endmodule

/* test/bridge_checker.sv */
// Bridge checker that predicts the DUT responses from the bridge rules and reports each test
`timescale 1ns/1ps

module bridge_checker import fpu_bridge_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_valid,
    input  esc_instr_t instr,
    input  logic       instr_ack,
    input  logic       data_write,
    input  word80_t    data_in,
    input  word80_t    data_out,
    input  logic       data_ready,
    input  logic       busy,
    input  logic       ready,
    input  logic       ctrl_write,
    input  word16_t    control_word,
    input  word16_t    fpu_control_reg,
    input  logic       fpu_control_update,
    input  word16_t    status_word,
    input  logic       exception,
    input  logic       irq,
    input  logic       fpu_start,
    input  core_req_t  fpu_req,
    input  core_rsp_t  fpu_rsp,
    output int         error_count,
    output int         tests_passed,
    output int         tests_failed,
    output int         instr_done
);

    esc_instr_t cur;
    logic       pend;
    logic       exp_need;
    logic       exp_res;
    logic       ready_seen;
    logic       reset_done;
    logic       ctrl_pend;
    logic       ctrl_busy;
    logic       exp_update;
    logic [1:0] cls;
    int         cyc;
    int         ack_cnt;
    int         ack_cyc;
    int         start_cnt;
    int         instr_errs;
    int         side;
    word80_t    last_operand;
    word80_t    exp_result;
    word16_t    ctrl_model;
    string      instr_name;
    string      test_name;   // Test the current checks belong to

    // Decode rule table returning {needs_operand, produces_result}
    function automatic logic [1:0] expect_class(logic [7:0] op, logic [7:0] mrm);
        logic [2:0] r;
        r = mrm[5:3];
        if (op[7:3] != 5'b11011) return 2'b00;   // Outside D8..DF
        if (mrm[7:6] == 2'b11) return {1'b0, (op == 8'hDF) && (mrm == 8'hE0)};
        case (op[2:0])
            3'd1:    return {(r == 3'd0) || (r == 3'd5), (r == 3'd2) || (r == 3'd7)};
            3'd3:    return {r != 3'd7, r == 3'd7};
            3'd5:    return {r == 3'd0, (r == 3'd2) || (r == 3'd7)};
            default: return 2'b10;
        endcase
    endfunction

    function automatic int mismatch(string name, logic [79:0] expected, logic [79:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s expected %0h actual %0h", test_name, name, expected,
                     actual);
            return 1;
        end
        return 0;
    endfunction

    task automatic finish_test(string name, int errs);
        error_count += errs;
        if (errs == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errs);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pend        = 1'b0;
            ctrl_pend   = 1'b0;
            ctrl_busy   = 1'b0;
            exp_update  = 1'b0;
            reset_done  = 1'b0;
            ctrl_model  = 16'h037F;
            error_count = 0;
            tests_passed = 0;
            tests_failed = 0;
            instr_done  = 0;
        end else begin
            if (!reset_done) begin
                reset_done = 1'b1;
                test_name  = "reset values";
                side = mismatch("instr_ack", 80'(0), 80'(instr_ack))
                     + mismatch("fpu_start", 80'(0), 80'(fpu_start))
                     + mismatch("data_ready", 80'(0), 80'(data_ready))
                     + mismatch("fpu_control_update", 80'(0), 80'(fpu_control_update))
                     + mismatch("busy", 80'(0), 80'(busy))
                     + mismatch("fpu_control_reg", 80'(16'h037F), 80'(fpu_control_reg));
                finish_test(test_name, side);
            end

            // ============================================================
            // Status mirror, ready and control word on every cycle
            // ============================================================
            if (ctrl_pend) begin
                test_name = ctrl_busy ? "ctrl write while busy" : "ctrl write in idle";
            end else if (pend) begin
                test_name = instr_name;
            end else begin
                test_name = "idle outputs";
            end
            side = mismatch("status_word", 80'(fpu_rsp.status), 80'(status_word))
                 + mismatch("exception", 80'(fpu_rsp.error & ~fpu_rsp.status[7]), 80'(exception))
                 + mismatch("irq", 80'(fpu_rsp.error & ~fpu_rsp.status[7]), 80'(irq))
                 + mismatch("ready", 80'(!busy), 80'(ready))
                 + mismatch("fpu_control_reg", 80'(ctrl_model), 80'(fpu_control_reg))
                 + mismatch("fpu_control_update", 80'(exp_update), 80'(fpu_control_update));
            if (ctrl_pend) begin
                finish_test(test_name, side);
                side = 0;
            end
            ctrl_pend  = ctrl_write;
            ctrl_busy  = busy;
            exp_update = ctrl_write && !busy;
            if (exp_update) ctrl_model = control_word;

            // ============================================================
            // Instruction in flight
            // ============================================================
            if (pend) begin
                test_name = instr_name;
                instr_errs += side;
                cyc++;
                if (instr_ack) begin
                    ack_cnt++;
                    ack_cyc = cyc;
                end
                if (data_write) last_operand = data_in;
                if (fpu_start) begin
                    start_cnt++;
                    instr_errs += mismatch("operation", 80'(cur.opcode), 80'(fpu_req.operation))
                        + mismatch("operand_select", 80'(cur.modrm), 80'(fpu_req.operand_select))
                        + mismatch("operand_data", exp_need ? last_operand : '0,
                                   fpu_req.operand_data);
                    if (!exp_need) begin
                        instr_errs += mismatch("ack to start", 80'(2), 80'(cyc - ack_cyc));
                    end
                end
                if (fpu_rsp.complete) exp_result = fpu_rsp.result;
                if (data_ready) begin
                    if (!exp_res && !ready_seen) begin
                        $display("instr %0d raised data_ready without a result", instr_done);
                        instr_errs++;
                    end
                    ready_seen = 1'b1;
                    instr_errs += mismatch("data_out", exp_result, data_out);
                end
                if (!busy) begin   // Instruction retired
                    instr_errs += mismatch("instr_ack count", 80'(1), 80'(ack_cnt))
                                + mismatch("fpu_start count", 80'(1), 80'(start_cnt));
                    if (exp_res && !ready_seen) begin
                        $display("instr %0d never raised data_ready for its result", instr_done);
                        instr_errs++;
                    end
                    finish_test(instr_name, instr_errs);
                    instr_done++;
                    pend = 1'b0;
                end
            end else begin
                error_count += side;
            end

            if (instr_valid && !busy) begin   // Accepted on this edge
                pend       = 1'b1;
                cur        = instr;
                instr_name = $sformatf("instr %0d %h %h", instr_done, instr.opcode,
                                       instr.modrm);
                cls        = expect_class(instr.opcode, instr.modrm);
                exp_need   = cls[1];
                exp_res    = cls[0];
                ready_seen = 1'b0;
                cyc        = 0;
                ack_cnt    = 0;
                ack_cyc    = 0;
                start_cnt  = 0;
                instr_errs = 0;
            end
        end
    end

endmodule

/* test/tb_fpu_cpu_bridge.sv */
// Bridge testbench: random CPU traffic, behavioral floating-point core and run limit
`timescale 1ns/1ps

module tb_fpu_cpu_bridge import fpu_bridge_pkg::*; ();

    localparam int NUM_INSTR      = 200;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + RESET_CYCLES;

    logic       clk;
    logic       reset;
    logic       instr_valid;
    esc_instr_t instr;
    logic       instr_ack;
    logic       data_write;
    word80_t    data_in;
    logic       data_read;
    word80_t    data_out;
    logic       data_ready;
    logic       busy;
    logic       ready;
    logic       ctrl_write;
    word16_t    control_word;
    word16_t    status_word;
    logic       exception;
    logic       irq;
    logic       fpu_start;
    core_req_t  fpu_req;
    core_rsp_t  fpu_rsp;
    word16_t    fpu_control_reg;
    logic       fpu_control_update;

    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          instr_done;
    int          cycle_count = 0;
    logic [31:0] seed = 32'd69;

    fpu_cpu_bridge #(.CTRL_RESET(16'h037F)) DUT (.*);

    bridge_checker scoreboard (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // LCG, halves swapped so low bits come from the better high bits
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_control();
        logic [31:0] r;
        r = next_rand();
        ctrl_write   = 1'b1;
        control_word = r[15:0];
        tick();
        ctrl_write = 1'b0;
    endtask

    // ============================================================
    // One ESC instruction from the CPU side
    // ============================================================
    task automatic run_instruction();
        logic [31:0] r;
        logic [31:0] r1;
        logic [31:0] r2;
        r = next_rand();
        instr_valid  = 1'b1;
        instr.opcode = (r[7:4] == 4'd0) ? r[15:8] : {5'b11011, r[2:0]};   // Mostly D8..DF
        instr.modrm  = r[23:16];
        do tick(); while (!instr_ack);
        instr_valid = 1'b0;
        r = next_rand();
        ctrl_write   = (r[1:0] == 2'd0);   // Lands while busy
        control_word = r[31:16];
        tick();
        ctrl_write = 1'b0;
        tick();
        if (!fpu_start) begin   // Bridge sits in data_wait
            r  = next_rand();
            r1 = next_rand();
            r2 = next_rand();
            repeat (r[1:0]) tick();
            data_write = 1'b1;
            data_in    = {r, r1, r2[15:0]};
            tick();
            data_write = 1'b0;
        end
        while (busy) begin
            data_read = data_ready;
            tick();
        end
        data_read = 1'b0;
    endtask

    // Core model: 1 to 4 cycles after a start, then one complete pulse
    initial begin : core_model
        logic [31:0] r;
        forever begin
            @(posedge clk);
            if (fpu_start) begin
                r = next_rand();
                repeat (r[1:0]) @(posedge clk);
                #1;
                fpu_rsp.complete = 1'b1;
                fpu_rsp.result   = fpu_req.operand_data
                                 ^ {64'd0, fpu_req.operation, fpu_req.operand_select};
                fpu_rsp.status   = r[31:16];
                fpu_rsp.error    = r[8];
                @(posedge clk);
                #1;
                fpu_rsp.complete = 1'b0;   // Status and error stay
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        data_write   = 1'b0;
        data_in      = '0;
        data_read    = 1'b0;
        ctrl_write   = 1'b0;
        control_word = '0;
        fpu_rsp      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < NUM_INSTR; i++) begin
            r = next_rand();
            if (r[3:0] < 4'd4) write_control();   // Idle-time write
            run_instruction();
        end
        repeat (4) tick();

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 error_count);
        if (instr_done != NUM_INSTR) begin
            $display("Only %0d of %0d instructions finished", instr_done, NUM_INSTR);
        end
        if (error_count == 0 && tests_failed == 0 && instr_done == NUM_INSTR) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* fpu_cpu_bridge.f */
src/fpu_bridge_pkg.sv
src/esc_decoder.sv
src/bridge_sequencer.sv
src/control_status.sv
src/fpu_cpu_bridge.sv
test/bridge_checker.sv
test/tb_fpu_cpu_bridge.sv

/* Makefile */
# Verilator build and run of the FPU/CPU bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_cpu_bridge
FILELIST  ?= fpu_cpu_bridge.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "No errors" $(LOG)

check:
	@grep -qx "No errors" $(LOG) || (echo "Pass line missing in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
